// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    // Where a decode operand comes from.
    typedef enum logic [1:0] {
        FWD_RF, FWD_EX, FWD_MEM, FWD_WB
    } fwd_sel_t;

    localparam word_t     RESET_PC = 32'hbfc0_0000;
    localparam reg_addr_t LINK_REG = 5'd31;

    // Primary opcodes.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function codes.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

// File: source/fetch_stage.sv
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  stall,
    input  wire logic  branch_taken,
    input  wire word_t branch_target,
    input  wire word_t inst_sram_rdata,
    output word_t      inst_sram_addr,
    output word_t      id_pc,
    output word_t      id_inst,
    output logic       id_valid
);

    word_t pc;
    word_t next_pc;
    logic  start;

    // Under stall the same address is presented again.
    always_comb begin
        if (stall) begin
            next_pc = pc;
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= RESET_PC - 32'd4;
            start <= 1'b0;
        end else begin
            pc    <= next_pc;
            start <= 1'b1;
        end
    end

    // The word returned this cycle belongs to pc.
    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc   <= pc;
            id_inst <= inst_sram_rdata;
        end
    end

    inst_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_sram_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/decode_ctrl.sv
`default_nettype none

module decode_ctrl import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  stall,
    input  wire word_t id_pc,
    input  wire word_t id_inst,
    input  wire logic  id_valid,
    input  wire word_t rs_data,
    input  wire word_t rt_data,
    output reg_addr_t  rs_addr,
    output reg_addr_t  rt_addr,
    output logic       rs_used,
    output logic       rt_used,
    output logic       branch_taken,
    output word_t      branch_target,
    output logic       ex_valid,
    output logic       ex_reg_write,
    output logic       ex_is_load,
    output logic       ex_is_store,
    output reg_addr_t  ex_dest,
    output alu_op_t    ex_alu_op,
    output word_t      ex_a,
    output word_t      ex_b,
    output word_t      ex_store_data,
    output word_t      ex_pc
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      seq_pc;
    word_t      alu_a;
    word_t      alu_b;
    reg_addr_t  dest;

    alu_op_t alu_op;
    logic    rs_use, rt_use, reg_write, is_load, is_store;
    logic    is_beq, is_bne, is_j, is_jr;
    logic    a_shamt, a_pc, b_imm, b_zext, b_eight, dest_rd, dest_link;

    assign opcode   = id_inst[31:26];
    assign rs_addr  = id_inst[25:21];
    assign rt_addr  = id_inst[20:16];
    assign rd       = id_inst[15:11];
    assign funct    = id_inst[5:0];
    assign imm_sext = {{16{id_inst[15]}}, id_inst[15:0]};
    assign imm_zext = {16'h0000, id_inst[15:0]};
    assign seq_pc   = id_pc + 32'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        alu_op    = ALU_ADD;
        rs_use    = 1'b0;
        rt_use    = 1'b0;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        is_jr     = 1'b0;
        a_shamt   = 1'b0;
        a_pc      = 1'b0;
        b_imm     = 1'b0;
        b_zext    = 1'b0;
        b_eight   = 1'b0;
        dest_rd   = 1'b0;
        dest_link = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                rs_use    = 1'b1;
                rt_use    = 1'b1;
                reg_write = 1'b1;
                dest_rd   = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL, FN_SRL: begin
                        alu_op  = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        rs_use  = 1'b0;
                        a_shamt = 1'b1;
                    end
                    FN_JR: begin
                        is_jr     = 1'b1;
                        rt_use    = 1'b0;
                        reg_write = 1'b0;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: begin
                rs_use    = 1'b1;
                b_imm     = 1'b1;
                is_load   = (opcode == OP_LW);
                is_store  = (opcode == OP_SW);
                rt_use    = (opcode == OP_SW);
                reg_write = (opcode != OP_SW);
            end
            OP_ANDI, OP_ORI: begin
                alu_op    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                rs_use    = 1'b1;
                b_imm     = 1'b1;
                b_zext    = 1'b1;
                reg_write = 1'b1;
            end
            OP_LUI: begin
                alu_op    = ALU_LUI;
                b_imm     = 1'b1;
                b_zext    = 1'b1;
                reg_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                rs_use = 1'b1;
                rt_use = 1'b1;
                is_beq = (opcode == OP_BEQ);
                is_bne = (opcode == OP_BNE);
            end
            OP_J: is_j = 1'b1;
            OP_JAL: begin
                is_j      = 1'b1;
                reg_write = 1'b1;
                dest_link = 1'b1;
                a_pc      = 1'b1;
                b_eight   = 1'b1;
            end
            default: ;
        endcase
    end

    assign rs_used = id_valid && rs_use;
    assign rt_used = id_valid && rt_use;

    // Resolved here, so the delay slot is the only wrong-path fetch.
    assign branch_taken = id_valid && (is_j || is_jr
                          || (is_beq && rs_data == rt_data)
                          || (is_bne && rs_data != rt_data));
    assign branch_target = is_jr ? rs_data
                         : is_j  ? {seq_pc[31:28], id_inst[25:0], 2'b00}
                         :         seq_pc + {imm_sext[29:0], 2'b00};

    // jal links pc + 8 through the adder.
    assign alu_a = a_pc    ? id_pc
                 : a_shamt ? {27'd0, id_inst[10:6]}
                 :           rs_data;
    assign alu_b = b_eight ? 32'd8
                 : b_imm   ? (b_zext ? imm_zext : imm_sext)
                 :           rt_data;
    assign dest  = dest_link ? LINK_REG : (dest_rd ? rd : rt_addr);

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_reg_write  <= reg_write;
        ex_is_load    <= is_load;
        ex_is_store   <= is_store;
        ex_dest       <= dest;
        ex_alu_op     <= alu_op;
        ex_a          <= alu_a;
        ex_b          <= alu_b;
        ex_store_data <= rt_data;
        ex_pc         <= id_pc;
    end

    // The bubble leaves no load in execute, so stall cannot repeat.
    stall_single_cycle: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire reg_addr_t rs_addr,
    input  wire reg_addr_t rt_addr,
    output word_t          rs_value,
    output word_t          rt_value,
    input  wire logic      wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire word_t     wr_data
);

    // Register zero has no storage.
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_value = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_value = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: source/operand_forward.sv
`default_nettype none

module operand_forward import cpu_pkg::*; (
    input  wire reg_addr_t rs_addr,
    input  wire reg_addr_t rt_addr,
    input  wire logic      rs_used,
    input  wire logic      rt_used,
    input  wire word_t     rs_value,
    input  wire word_t     rt_value,
    input  wire logic      ex_valid,
    input  wire logic      ex_reg_write,
    input  wire logic      ex_is_load,
    input  wire reg_addr_t ex_dest,
    input  wire word_t     ex_result,
    input  wire logic      mem_valid,
    input  wire logic      mem_reg_write,
    input  wire reg_addr_t mem_dest,
    input  wire word_t     mem_result,
    input  wire logic      wb_valid,
    input  wire logic      wb_reg_write,
    input  wire reg_addr_t wb_dest,
    input  wire word_t     wb_result,
    output word_t          rs_data,
    output word_t          rt_data,
    output logic           stall
);

    fwd_sel_t rs_sel;
    fwd_sel_t rt_sel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Source selection, youngest writer first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic fwd_sel_t pick_source(input reg_addr_t addr);
        if (addr == '0) begin
            return FWD_RF;
        end else if (ex_valid && ex_reg_write && ex_dest == addr) begin
            return FWD_EX;
        end else if (mem_valid && mem_reg_write && mem_dest == addr) begin
            return FWD_MEM;
        end else if (wb_valid && wb_reg_write && wb_dest == addr) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    function automatic word_t pick_value(input fwd_sel_t sel, input word_t rf_value);
        case (sel)
            FWD_EX:  return ex_result;
            FWD_MEM: return mem_result;
            FWD_WB:  return wb_result;
            default: return rf_value;
        endcase
    endfunction

    always_comb begin
        rs_sel  = pick_source(rs_addr);
        rt_sel  = pick_source(rt_addr);
        rs_data = pick_value(rs_sel, rs_value);
        rt_data = pick_value(rt_sel, rt_value);
    end

    // A load in execute has no data yet; hold decode one cycle.
    assign stall = ex_valid && ex_is_load
                   && ((rs_used && rs_sel == FWD_EX) || (rt_used && rt_sel == FWD_EX));

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      ex_valid,
    input  wire logic      ex_reg_write,
    input  wire logic      ex_is_load,
    input  wire logic      ex_is_store,
    input  wire reg_addr_t ex_dest,
    input  wire alu_op_t   ex_alu_op,
    input  wire word_t     ex_a,
    input  wire word_t     ex_b,
    input  wire word_t     ex_store_data,
    input  wire word_t     ex_pc,
    output word_t          ex_result,
    output logic           data_sram_en,
    output byte_en_t       data_sram_wen,
    output word_t          data_sram_addr,
    output word_t          data_sram_wdata,
    output logic           mem_valid,
    output logic           mem_reg_write,
    output logic           mem_is_load,
    output reg_addr_t      mem_dest,
    output word_t          mem_alu_result,
    output word_t          mem_pc
);

    // Shifts take the amount in a and the value in b.
    always_comb begin
        case (ex_alu_op)
            ALU_ADD:  ex_result = ex_a + ex_b;
            ALU_SUB:  ex_result = ex_a - ex_b;
            ALU_AND:  ex_result = ex_a & ex_b;
            ALU_OR:   ex_result = ex_a | ex_b;
            ALU_XOR:  ex_result = ex_a ^ ex_b;
            ALU_SLT:  ex_result = {31'd0, $signed(ex_a) < $signed(ex_b)};
            ALU_SLTU: ex_result = {31'd0, ex_a < ex_b};
            ALU_SLL:  ex_result = ex_b << ex_a[4:0];
            ALU_SRL:  ex_result = ex_b >> ex_a[4:0];
            ALU_LUI:  ex_result = {ex_b[15:0], 16'h0000};
            default:  ex_result = ex_a + ex_b;
        endcase
    end

    // Word access only, the sum is the address.
    assign data_sram_en    = ex_valid && (ex_is_load || ex_is_store);
    assign data_sram_wen   = (ex_valid && ex_is_store) ? 4'hf : 4'h0;
    assign data_sram_addr  = ex_result;
    assign data_sram_wdata = ex_store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_reg_write  <= ex_reg_write;
        mem_is_load    <= ex_is_load;
        mem_dest       <= ex_dest;
        mem_alu_result <= ex_result;
        mem_pc         <= ex_pc;
    end

    // Decode never marks a store as a register writer.
    store_no_reg_write: assert property (@(posedge clk) disable iff (reset)
        data_sram_wen != '0 |-> ex_valid && ex_is_store && !ex_reg_write);

endmodule

`default_nettype wire

// File: source/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      mem_valid,
    input  wire logic      mem_reg_write,
    input  wire logic      mem_is_load,
    input  wire reg_addr_t mem_dest,
    input  wire word_t     mem_alu_result,
    input  wire word_t     mem_pc,
    input  wire word_t     data_sram_rdata,
    output word_t          mem_result,
    output logic           wb_valid,
    output logic           wb_reg_write,
    output reg_addr_t      wb_dest,
    output word_t          wb_result,
    output word_t          debug_wb_pc,
    output byte_en_t       debug_wb_rf_wen,
    output reg_addr_t      debug_wb_rf_wnum,
    output word_t          debug_wb_rf_wdata
);

    word_t wb_pc;

    // Load data lands this cycle.
    assign mem_result = mem_is_load ? data_sram_rdata : mem_alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_valid     <= mem_valid;
            wb_reg_write <= mem_valid && mem_reg_write && mem_dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest   <= mem_dest;
        wb_result <= mem_result;
        wb_pc     <= mem_pc;
    end

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_valid && wb_reg_write}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_result;

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    output logic       inst_sram_en,
    output byte_en_t   inst_sram_wen,
    output word_t      inst_sram_addr,
    input  wire word_t inst_sram_rdata,
    output logic       data_sram_en,
    output byte_en_t   data_sram_wen,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  wire word_t data_sram_rdata,
    output word_t      debug_wb_pc,
    output byte_en_t   debug_wb_rf_wen,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    // Fetch to decode.
    word_t     id_pc;
    word_t     id_inst;
    logic      id_valid;
    logic      stall;
    logic      branch_taken;
    word_t     branch_target;

    // Register read and forwarding.
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    logic      rs_used;
    logic      rt_used;
    word_t     rs_value;
    word_t     rt_value;
    word_t     rs_data;
    word_t     rt_data;

    // Decode to execute.
    logic      ex_valid;
    logic      ex_reg_write;
    logic      ex_is_load;
    logic      ex_is_store;
    reg_addr_t ex_dest;
    alu_op_t   ex_alu_op;
    word_t     ex_a;
    word_t     ex_b;
    word_t     ex_store_data;
    word_t     ex_pc;
    word_t     ex_result;

    // Execute to memory, memory to writeback.
    logic      mem_valid;
    logic      mem_reg_write;
    logic      mem_is_load;
    reg_addr_t mem_dest;
    word_t     mem_alu_result;
    word_t     mem_pc;
    word_t     mem_result;
    logic      wb_valid;
    logic      wb_reg_write;
    reg_addr_t wb_dest;
    word_t     wb_result;

    assign inst_sram_en  = 1'b1;
    assign inst_sram_wen = '0;

    fetch_stage fetch0 (
        .clk, .reset, .stall, .branch_taken, .branch_target,
        .inst_sram_rdata, .inst_sram_addr,
        .id_pc, .id_inst, .id_valid
    );

    decode_ctrl decode0 (
        .clk, .reset, .stall, .id_pc, .id_inst, .id_valid,
        .rs_data, .rt_data, .rs_addr, .rt_addr, .rs_used, .rt_used,
        .branch_taken, .branch_target,
        .ex_valid, .ex_reg_write, .ex_is_load, .ex_is_store,
        .ex_dest, .ex_alu_op, .ex_a, .ex_b, .ex_store_data, .ex_pc
    );

    reg_file regs0 (
        .clk, .rs_addr, .rt_addr, .rs_value, .rt_value,
        .wr_en   (wb_reg_write),
        .wr_addr (wb_dest),
        .wr_data (wb_result)
    );

    operand_forward forward0 (
        .rs_addr, .rt_addr, .rs_used, .rt_used, .rs_value, .rt_value,
        .ex_valid, .ex_reg_write, .ex_is_load, .ex_dest, .ex_result,
        .mem_valid, .mem_reg_write, .mem_dest, .mem_result,
        .wb_valid, .wb_reg_write, .wb_dest, .wb_result,
        .rs_data, .rt_data, .stall
    );

    execute_stage execute0 (
        .clk, .reset,
        .ex_valid, .ex_reg_write, .ex_is_load, .ex_is_store,
        .ex_dest, .ex_alu_op, .ex_a, .ex_b, .ex_store_data, .ex_pc,
        .ex_result,
        .data_sram_en, .data_sram_wen, .data_sram_addr, .data_sram_wdata,
        .mem_valid, .mem_reg_write, .mem_is_load, .mem_dest,
        .mem_alu_result, .mem_pc
    );

    mem_wb_stage mem_wb0 (
        .clk, .reset,
        .mem_valid, .mem_reg_write, .mem_is_load, .mem_dest,
        .mem_alu_result, .mem_pc, .data_sram_rdata,
        .mem_result, .wb_valid, .wb_reg_write, .wb_dest, .wb_result,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

`default_nettype wire

// File: verif/tb_memory.sv
`default_nettype none

module tb_memory import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     inst_en,
    input  wire byte_en_t inst_wen,
    input  wire word_t    inst_addr,
    output word_t         inst_rdata,
    input  wire logic     data_en,
    input  wire byte_en_t data_wen,
    input  wire word_t    data_addr,
    input  wire word_t    data_wdata,
    output word_t         data_rdata
);

    // 256 words each, indexed by address bits 9:2.
    word_t inst_mem [0:255];
    word_t data_mem [0:255];

    initial begin
        for (int i = 0; i < 256; i++) begin
            inst_mem[i] = '0;
            data_mem[i] = '0;
        end
        inst_rdata = '0;
        data_rdata = '0;
    end

    task automatic load_inst(input word_t addr, input word_t data);
        inst_mem[addr[9:2]] = data;
    endtask

    // Read first, then write; read data appears just after the edge.
    always @(posedge clk) begin : sram_ports
        word_t inst_word;
        word_t data_word;
        logic  inst_read;
        logic  data_read;
        inst_word = inst_mem[inst_addr[9:2]];
        data_word = data_mem[data_addr[9:2]];
        inst_read = inst_en && (inst_wen == '0);
        data_read = data_en;
        if (data_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_wen[b]) begin
                    data_mem[data_addr[9:2]][8*b +: 8] = data_wdata[8*b +: 8];
                end
            end
        end
        #1;
        if (inst_read) begin
            inst_rdata = inst_word;
        end
        if (data_read) begin
            data_rdata = data_word;
        end
    end

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      inst_sram_en;
    byte_en_t  inst_sram_wen;
    word_t     inst_sram_addr;
    word_t     inst_sram_rdata;
    logic      data_sram_en;
    byte_en_t  data_sram_wen;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    word_t     data_sram_rdata;
    word_t     debug_wb_pc;
    byte_en_t  debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    // Expected writebacks in program order.
    word_t     exp_pc   [0:255];
    reg_addr_t exp_num  [0:255];
    word_t     exp_data [0:255];
    integer    exp_count   = 0;
    integer    inst_count  = 0;
    logic      loaded      = 1'b0;

    cpu_top dut0 (
        .clk, .reset,
        .inst_sram_en, .inst_sram_wen, .inst_sram_addr, .inst_sram_rdata,
        .data_sram_en, .data_sram_wen, .data_sram_addr, .data_sram_wdata,
        .data_sram_rdata,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    tb_memory mem0 (
        .clk,
        .inst_en    (inst_sram_en),
        .inst_wen   (inst_sram_wen),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_en    (data_sram_en),
        .data_wen   (data_sram_wen),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure handling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at time %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : read_stim
        integer           fd;
        integer           code;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        word_t            a;
        word_t            b;
        word_t            c;
        #1;
        fd = $fopen("verif/program_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file verif/program_stim.txt.");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
                if (tag == "I") begin
                    code = $fscanf(fd, "%h %h", a, b);
                    mem0.load_inst(a, b);
                    inst_count++;
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                    exp_pc[exp_count]   = a;
                    exp_num[exp_count]  = b[4:0];
                    exp_data[exp_count] = c;
                    exp_count++;
                end else begin
                    code = $fgets(rest, fd);
                end
            end
        end
        $fclose(fd);
        if (exp_count == 0 || inst_count == 0) begin
            abort_run("The stimulus file holds no program or no expected trace.");
        end
        loaded = 1'b1;
    end

    // The trace is sampled mid-cycle.
    initial begin : check_trace
        integer idx;
        idx = 0;
        wait (loaded);
        while (idx < exp_count) begin
            @(negedge clk);
            if (debug_wb_rf_wen != 4'h0) begin
                check_value("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'hf);
                check_value("debug_wb_pc", debug_wb_pc, exp_pc[idx]);
                check_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum},
                            {27'd0, exp_num[idx]});
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[idx]);
                idx++;
            end
        end
        $display("TEST PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        repeat (20 * inst_count + 100) @(posedge clk);
        abort_run("Timeout: the writeback trace was not completed in time.");
    end

endmodule

`default_nettype wire

// File: verif/program_stim.txt
# I <address> <instruction>
# E <pc> <register> <data>   expected writebacks in program order
I bfc00000 24010005
I bfc00004 2402fffd
I bfc00008 00221821
I bfc0000c 00222023
I bfc00010 00642824
I bfc00014 00643025
I bfc00018 00c13826
I bfc0001c 0041402a
I bfc00020 0041482b
I bfc00024 00015100
I bfc00028 00025a02
I bfc0002c 3c0c1234
I bfc00030 358c5678
I bfc00034 318dff0f
I bfc00038 ac0c0040
I bfc0003c 8c0e0040
I bfc00040 01c17821
I bfc00044 24000007
I bfc00048 00018021
I bfc0004c 10220002
I bfc00050 24110001
I bfc00054 24120002
I bfc00058 14220002
I bfc0005c 24130003
I bfc00060 24140004
I bfc00064 12310002
I bfc00068 24150005
I bfc0006c 24160006
I bfc00070 14210002
I bfc00074 24170007
I bfc00078 0ff00022
I bfc0007c 24180008
I bfc00080 0bf00024
I bfc00084 24190009
I bfc00088 03e00008
I bfc0008c 241a000a
I bfc00090 033ad821
I bfc00094 0bf00025
I bfc00098 00000000
E bfc00000 01 00000005
E bfc00004 02 fffffffd
E bfc00008 03 00000002
E bfc0000c 04 00000008
E bfc00010 05 00000000
E bfc00014 06 0000000a
E bfc00018 07 0000000f
E bfc0001c 08 00000001
E bfc00020 09 00000000
E bfc00024 0a 00000050
E bfc00028 0b 00ffffff
E bfc0002c 0c 12340000
E bfc00030 0c 12345678
E bfc00034 0d 00005608
E bfc0003c 0e 12345678
E bfc00040 0f 1234567d
E bfc00048 10 00000005
E bfc00050 11 00000001
E bfc00054 12 00000002
E bfc0005c 13 00000003
E bfc00068 15 00000005
E bfc00074 17 00000007
E bfc00078 1f bfc00080
E bfc0007c 18 00000008
E bfc0008c 1a 0000000a
E bfc00084 19 00000009
E bfc00090 1b 00000013

// File: list.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_ctrl.sv
source/reg_file.sv
source/operand_forward.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/cpu_top.sv
verif/tb_memory.sv
verif/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; success requires the pass line in the output.
verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim \
    && ./obj_dir/cpu_sim | grep "TEST PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
